/* bench/cpuControlModel.svh */
// Cycle model of state, sub-cycle, interrupt enable, synchroniser, status and expected outputs
`ifndef CPU_CONTROL_MODEL_SVH
`define CPU_CONTROL_MODEL_SVH

// Model registers and their values for the next clock
state_t mState;
state_t mStateNext;
busCycle_t mCycle;
busCycle_t mCycleNext;
logic mIntEn;
logic mIntEnNext;
logic [`CPU_IRQ_STAGES-1:0] mSync;
logic [`CPU_IRQ_STAGES-1:0] mSyncNext;
logic [`CPU_FLAG_WIDTH-1:0] mStatus;
logic [`CPU_FLAG_WIDTH-1:0] mStatusNext;
int intEntries;

// Expected outputs in the current cycle
logic expALE;
logic expNME;
logic expNOE;
logic expNWE;
logic expENB;
logic expMemEn;
logic expIrWe;
logic expRegWe;
logic expStatusRegWe;
logic expPcWe;
logic expPcEn;
logic expLrWe;
logic expAluEn;
logic expAluWe;
logic expIntEnable;
logic expIntDisable;
pcSelect_t expPcSel;
rwSelect_t expRwSel;
wdSelect_t expWdSel;
aluOrSelect_t expAluOR;
immSelect_t expImmSel;
op1Select_t expOp1Sel;
op2Select_t expOp2Sel;
rs1Select_t expRs1Sel;

function automatic logic isAluOp(opcode_t op);
	return op inside {ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI,
		CMP, CMPI, AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, NEG};
endfunction

function automatic logic isMemOp(opcode_t op);
	return (op == LDW) || (op == STW);
endfunction

// Condition table on the model's own status
function automatic logic branchCondition(logic [`CPU_FLAG_WIDTH-1:0] status, logic [2:0] code);
	case (branch_t'(code))
		BR, BWL, JMP:
			return 1'b1;
		BNE:
			return !status[`CPU_FLAG_Z];
		BE:
			return status[`CPU_FLAG_Z];
		BLT:
			return status[`CPU_FLAG_N] != status[`CPU_FLAG_V];
		BGE:
			return status[`CPU_FLAG_N] == status[`CPU_FLAG_V];
		default:
			return 1'b0;
	endcase
endfunction

task automatic modelReset();
	mState = fetch;
	mCycle = cycle0;
	mIntEn = 1'b0;
	mSync = '0;
	mStatus = '0;
	intEntries = 0;
endtask

task automatic computeExpected(input opcode_t op, input logic [2:0] code, input logic waitIn);
	logic readCycle;
	// Address strobe and memory enable follow the sub-cycle alone
	expALE = (mCycle == cycle0);
	expNME = !((mCycle == cycle1) || (mCycle == cycle2));
	// Memory read for instruction fetch and LDW data
	readCycle = (mCycle == cycle2) &&
		((mState == fetch) || ((mState == execute) && (op == LDW)));
	expNOE = !readCycle;
	expENB = readCycle;
	expMemEn = readCycle;
	expNWE = 1'b1;
	expIrWe = 1'b0;
	expRegWe = 1'b0;
	expStatusRegWe = 1'b0;
	expPcWe = 1'b0;
	expPcEn = 1'b0;
	expLrWe = 1'b0;
	expAluEn = 1'b0;
	expAluWe = 1'b0;
	expIntEnable = 1'b0;
	expIntDisable = 1'b0;
	expPcSel = Pc1;
	expRwSel = RwRd;
	expWdSel = WdAlu;
	expAluOR = NoOr;
	expImmSel = ImmLong;
	expOp1Sel = Op1Rd1;
	expOp2Sel = Op2Imm;
	expRs1Sel = Rs1Ra;
	case (mState)
		fetch: begin
			expIrWe = (mCycle == cycle2) && waitIn;
			expPcEn = (mCycle != cycle2);
		end
		execute:
			if (mCycle == cycle4) begin
				if (isAluOp(op)) begin
					expRegWe = (op != CMP) && (op != CMPI);
					expStatusRegWe = 1'b1;
					expPcWe = 1'b1;
					expPcEn = 1'b1;
					// Operand routing by instruction format
					if (op inside {ADD, ADC, SUB, CMP, AND, OR, XOR, NAND, NOR})
						expOp2Sel = Op2Rd2;
					else if (op inside {ADDI, ADCI, SUBI, CMPI, LSL, LSR, ASR})
						expImmSel = ImmShort;
					else if (op inside {ADDIB, SUBIB})
						expRs1Sel = Rs1Rd;
				end else if ((op == LUI) || (op == LLI)) begin
					expRegWe = 1'b1;
					expPcWe = 1'b1;
					expAluEn = 1'b1;
					expRs1Sel = Rs1Rd;
				end else if (isMemOp(op)) begin
					// Effective address into the ALU register
					expImmSel = ImmShort;
					expAluEn = 1'b1;
					expAluWe = 1'b1;
				end else if (op == BRANCH) begin
					expPcWe = 1'b1;
					expAluEn = 1'b1;
					if (branch_t'(code) == JMP)
						expImmSel = ImmShort;
					else
						expOp1Sel = Op1Pc;
					if (branchCondition(mStatus, code))
						expPcSel = PcAluOut;
					expLrWe = (branch_t'(code) == BWL);
				end else if (op == INTERRUPT) begin
					expPcWe = 1'b1;
					expPcEn = 1'b1;
					expIntEnable = (intCode_t'(code) == IntOn);
					expIntDisable = (intCode_t'(code) == IntOff);
				end
			end else if (mCycle == cycle0) begin
				expImmSel = ImmShort;
				expAluEn = 1'b1;
			end else if (mCycle == cycle1) begin
				// Rd through the ALU for the data phase
				expOp2Sel = Op2Zero;
				expRs1Sel = Rs1Rd;
				expAluEn = 1'b1;
				expAluWe = 1'b1;
			end else if (mCycle == cycle2) begin
				expPcWe = waitIn;
				if (op == LDW) begin
					expRegWe = 1'b1;
					expWdSel = WdSys;
				end else begin
					expAluEn = 1'b1;
					expOp2Sel = Op2Zero;
				end
			end else if (mCycle == cycle3) begin
				expNWE = (op != STW);
				if (op == STW) begin
					expAluEn = 1'b1;
					expOp2Sel = Op2Zero;
				end else begin
					expPcEn = 1'b1;
				end
			end
		interrupt: begin
			// Stack pointer minus one for the push address
			if ((mCycle == cycle4) || (mCycle == cycle0)) begin
				expRs1Sel = Rs1Seven;
				expAluOR = SubOr;
			end
			if (mCycle inside {cycle4, cycle0, cycle1}) begin
				expOp2Sel = Op2Zero;
				expAluEn = 1'b1;
			end
			expPcEn = (mCycle == cycle2) || (mCycle == cycle3);
			if (mCycle == cycle4) begin
				expIntDisable = 1'b1;
				expRegWe = 1'b1;
				expRwSel = RwSeven;
				expAluWe = 1'b1;
			end else if (mCycle == cycle2) begin
				// PC push
				expNWE = 1'b0;
			end else if (mCycle == cycle3) begin
				expPcWe = 1'b1;
				expPcSel = PcInt;
			end
		end
		default: ;
	endcase
endtask

// Next model state from the values present before the clock edge
task automatic modelStep(input opcode_t op, input logic waitIn, input logic irqIn,
		input logic [`CPU_FLAG_WIDTH-1:0] flagsIn, input logic resetIn);
	logic intReq;
	logic finish;
	intReq = mSync[`CPU_IRQ_STAGES-1] & mIntEn;
	finish = 1'b0;
	mStateNext = mState;
	mCycleNext = mCycle;
	mSyncNext = {mSync[`CPU_IRQ_STAGES-2:0], ~irqIn};
	mIntEnNext = expIntDisable ? 1'b0 : (expIntEnable ? 1'b1 : mIntEn);
	mStatusNext = expStatusRegWe ? flagsIn : mStatus;
	case (mCycle)
		cycle0:
			mCycleNext = cycle1;
		cycle1:
			mCycleNext = cycle2;
		cycle2:
			if (waitIn || (mState == interrupt))
				mCycleNext = cycle3;
		cycle3:
			if (mState == fetch) begin
				mStateNext = execute;
				mCycleNext = cycle4;
			end else if (mState == execute) begin
				finish = 1'b1;
			end else begin
				mStateNext = fetch;
				mCycleNext = cycle0;
			end
		cycle4:
			if ((mState == interrupt) || isMemOp(op))
				mCycleNext = cycle0;
			else
				finish = 1'b1;
		default: ;
	endcase
	if (finish) begin
		mStateNext = intReq ? interrupt : fetch;
		mCycleNext = intReq ? cycle4 : cycle0;
	end
	if (!resetIn) begin
		mStateNext = fetch;
		mCycleNext = cycle0;
		mIntEnNext = 1'b0;
		mSyncNext = '0;
		mStatusNext = '0;
	end
endtask

task automatic modelCommit();
	if ((mStateNext == interrupt) && (mState != interrupt))
		intEntries++;
	mState = mStateNext;
	mCycle = mCycleNext;
	mIntEn = mIntEnNext;
	mSync = mSyncNext;
	mStatus = mStatusNext;
endtask

`endif

/* bench/tbCpuControl.sv */
// Testbench for cpuControl with clock, reset, random stimulus, model checks and report
`include "cpuControl_params.svh"

module tbCpuControl;

	import cpuControlPkg::*;

	localparam int INSTR_COUNT = 400;
	// Worst case of about 20 cycles per instruction with stalls and interrupt entry
	localparam int CYCLE_LIMIT = INSTR_COUNT * 20;
	localparam int RESET_CYCLES = 10;

	logic Clock;
	logic nReset;
	logic nIRQ;
	logic nWait;
	logic [`CPU_FLAG_WIDTH-1:0] Flags;
	logic [`CPU_OPCODE_WIDTH+`CPU_CODE_WIDTH-1:0] OpcodeCondIn;
	logic ALE;
	logic AluEn;
	logic AluWe;
	aluOrSelect_t AluOR;
	logic ENB;
	immSelect_t ImmSel;
	logic IrWe;
	logic LrWe;
	logic MemEn;
	logic nME;
	logic nOE;
	logic nWE;
	op1Select_t Op1Sel;
	op2Select_t Op2Sel;
	logic PcEn;
	pcSelect_t PcSel;
	logic PcWe;
	logic RegWe;
	rs1Select_t Rs1Sel;
	rwSelect_t RwSel;
	wdSelect_t WdSel;
	logic StatusRegWe;
	logic [`CPU_FLAG_WIDTH-1:0] StatusReg;
	logic CFlag;

	integer seed;
	int cycleCount;
	int instrCount;
	int checkCount;
	int mismatchCount;
	int failureCount;

	`include "cpuControlModel.svh"

	cpuControl u_cpuControl (
		.Clock(Clock), .nReset(nReset), .nIRQ(nIRQ), .nWait(nWait),
		.Flags(Flags), .OpcodeCondIn(OpcodeCondIn),
		.ALE(ALE), .AluEn(AluEn), .AluWe(AluWe), .AluOR(AluOR), .ENB(ENB),
		.ImmSel(ImmSel), .IrWe(IrWe), .LrWe(LrWe), .MemEn(MemEn),
		.nME(nME), .nOE(nOE), .nWE(nWE), .Op1Sel(Op1Sel), .Op2Sel(Op2Sel),
		.PcEn(PcEn), .PcSel(PcSel), .PcWe(PcWe), .RegWe(RegWe),
		.Rs1Sel(Rs1Sel), .RwSel(RwSel), .WdSel(WdSel),
		.StatusRegWe(StatusRegWe), .StatusReg(StatusReg), .CFlag(CFlag)
	);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	task automatic checkBit(input string testName, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			mismatchCount++;
			$display("Mismatch in %s at cycle %0d: expected %0h, actual %0h",
				testName, cycleCount, expected, actual);
		end
	endtask

	task automatic checkField(input string testName, input logic [3:0] expected,
			input logic [3:0] actual);
		checkCount++;
		if (actual !== expected) begin
			mismatchCount++;
			$display("Mismatch in %s at cycle %0d: expected %0h, actual %0h",
				testName, cycleCount, expected, actual);
		end
	endtask

	// Kept instructions only, with extra weight on the interrupt codes
	task automatic pickInstruction(output logic [7:0] instr);
		logic [31:0] r;
		logic [4:0] op;
		logic [2:0] code;
		r = $random(seed);
		op = r[4:0];
		code = r[10:8];
		if (op > 5'd27)
			op = INTERRUPT;
		if (op == BRANCH)
			code = 3'(r[15:8] % 8'd7);
		else if (op == INTERRUPT)
			code = (r[17:16] == 2'b00) ? IntOff : IntOn;
		instr = {op, code};
	endtask

	function automatic string phaseName(opcode_t op, logic resetIn);
		if (!resetIn)
			return "reset";
		if (mState == fetch)
			return "fetch";
		if (mState == interrupt)
			return "interrupt entry";
		if (mCycle != cycle4 || isMemOp(op))
			return "memory op";
		if (isAluOp(op))
			return "alu op";
		if (op == BRANCH)
			return "branch";
		if (op == INTERRUPT)
			return "interrupt code";
		return "load immediate";
	endfunction

	task automatic checkOutputs(input string phase);
		checkBit({phase, " ALE"}, expALE, ALE);
		checkBit({phase, " nME"}, expNME, nME);
		checkBit({phase, " nOE"}, expNOE, nOE);
		checkBit({phase, " nWE"}, expNWE, nWE);
		checkBit({phase, " ENB"}, expENB, ENB);
		checkBit({phase, " MemEn"}, expMemEn, MemEn);
		checkBit({phase, " IrWe"}, expIrWe, IrWe);
		checkBit({phase, " RegWe"}, expRegWe, RegWe);
		checkBit({phase, " StatusRegWe"}, expStatusRegWe, StatusRegWe);
		checkBit({phase, " PcWe"}, expPcWe, PcWe);
		checkBit({phase, " PcEn"}, expPcEn, PcEn);
		checkBit({phase, " LrWe"}, expLrWe, LrWe);
		checkBit({phase, " AluEn"}, expAluEn, AluEn);
		checkBit({phase, " AluWe"}, expAluWe, AluWe);
		checkField({phase, " AluOR"}, 4'(expAluOR), 4'(AluOR));
		checkField({phase, " PcSel"}, 4'(expPcSel), 4'(PcSel));
		checkBit({phase, " RwSel"}, expRwSel, RwSel);
		checkBit({phase, " WdSel"}, expWdSel, WdSel);
		checkBit({phase, " ImmSel"}, expImmSel, ImmSel);
		checkBit({phase, " Op1Sel"}, expOp1Sel, Op1Sel);
		checkField({phase, " Op2Sel"}, 4'(expOp2Sel), 4'(Op2Sel));
		checkField({phase, " Rs1Sel"}, 4'(expRs1Sel), 4'(Rs1Sel));
		// Interrupt enable strobes are internal to the top level
		checkBit({phase, " IntEnable"}, expIntEnable, u_cpuControl.intEnable);
		checkBit({phase, " IntDisable"}, expIntDisable, u_cpuControl.intDisable);
		checkField({phase, " StatusReg"}, mStatus, StatusReg);
		checkBit({phase, " CFlag"}, mStatus[`CPU_FLAG_C], CFlag);
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0] nextInstr;
		logic fetched;
		opcode_t op;
		logic [2:0] code;
		seed = 57;
		cycleCount = 0;
		instrCount = 0;
		checkCount = 0;
		mismatchCount = 0;
		failureCount = 0;
		nReset = 1'b0;
		nIRQ = 1'b1;
		nWait = 1'b1;
		Flags = '0;
		OpcodeCondIn = '0;
		modelReset();
		while ((instrCount < INSTR_COUNT) && (cycleCount < CYCLE_LIMIT)) begin
			// Outputs are settled half a period after the inputs changed
			@(negedge Clock);
			op = opcode_t'(OpcodeCondIn[`CPU_OPCODE_WIDTH+`CPU_CODE_WIDTH-1:`CPU_CODE_WIDTH]);
			code = OpcodeCondIn[`CPU_CODE_WIDTH-1:0];
			computeExpected(op, code, nWait);
			checkOutputs(phaseName(op, nReset));
			fetched = nReset && IrWe;
			if (fetched)
				instrCount++;
			modelStep(op, nWait, nIRQ, Flags, nReset);
			@(posedge Clock);
			modelCommit();
			cycleCount++;
			if (cycleCount >= RESET_CYCLES)
				nReset <= 1'b1;
			r = $random(seed);
			Flags <= r[3:0];
			nWait <= (r[5:4] != 2'b00);
			nIRQ <= (r[11:8] != 4'd0);
			// Next instruction word once the current one is latched
			if (fetched) begin
				pickInstruction(nextInstr);
				OpcodeCondIn <= nextInstr;
			end
		end
		if (instrCount < INSTR_COUNT) begin
			failureCount++;
			$display("Timeout after %0d cycles, only %0d of %0d instructions were fetched",
				cycleCount, instrCount, INSTR_COUNT);
		end
		if (intEntries == 0) begin
			failureCount++;
			$display("No interrupt entry took place during the run");
		end
		$display("Checks %0d, mismatches %0d, other failures %0d",
			checkCount, mismatchCount, failureCount);
		if ((mismatchCount == 0) && (failureCount == 0)) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* cpuControl.f */
+incdir+source
+incdir+bench
source/cpuControlPkg.sv
source/irqSync.sv
source/statusFlags.sv
source/busCycleCounter.sv
source/controlSequencer.sv
source/controlDecode.sv
source/cpuControl.sv
bench/tbCpuControl.sv

/* run.sh */
#!/bin/sh
# Build the control unit testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tbCpuControl -f cpuControl.f \
	--Mdir obj_dir -o simCpuControl

./obj_dir/simCpuControl > sim.log
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failure"
exit 0

/* source/busCycleCounter.sv */
// Bus sub-cycle counter with nWait stall and start-cycle load
module busCycleCounter (
	input  logic Clock,
	input  logic nReset,
	input  logic nWait,
	input  logic Load,
	input  cpuControlPkg::busCycle_t LoadCycle,
	output cpuControlPkg::busCycle_t Cycle
);

	import cpuControlPkg::*;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			Cycle <= cycle0;
		end else if (Load) begin
			Cycle <= LoadCycle;
		end else begin
			case (Cycle)
				cycle0:
					Cycle <= cycle1;
				cycle1:
					Cycle <= cycle2;
				// Data setup, held while memory is slow
				cycle2:
					if (nWait)
						Cycle <= cycle3;
				// cycle3 and cycle4 only leave by a load
				default:
					Cycle <= Cycle;
			endcase
		end
	end

endmodule

/* source/controlDecode.sv */
// Decoder from state, sub-cycle and instruction to strobes and selects
`include "cpuControl_params.svh"

module controlDecode (
	input  cpuControlPkg::state_t State,
	input  cpuControlPkg::busCycle_t Cycle,
	input  logic [`CPU_OPCODE_WIDTH+`CPU_CODE_WIDTH-1:0] OpcodeCondIn,
	input  logic BranchTaken,
	input  logic nWait,
	output logic ALE,
	output logic AluEn,
	output logic AluWe,
	output cpuControlPkg::aluOrSelect_t AluOR,
	output logic ENB,
	output cpuControlPkg::immSelect_t ImmSel,
	output logic IrWe,
	output logic LrWe,
	output logic MemEn,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output cpuControlPkg::op1Select_t Op1Sel,
	output cpuControlPkg::op2Select_t Op2Sel,
	output logic PcEn,
	output cpuControlPkg::pcSelect_t PcSel,
	output logic PcWe,
	output logic RegWe,
	output cpuControlPkg::rs1Select_t Rs1Sel,
	output cpuControlPkg::rwSelect_t RwSel,
	output cpuControlPkg::wdSelect_t WdSel,
	output logic StatusRegWe,
	output logic IntEnable,
	output logic IntDisable
);

	import cpuControlPkg::*;

	opcode_t opcode;
	branch_t branchCode;
	intCode_t intCode;
	logic aluOp;

	assign opcode = opcode_t'(OpcodeCondIn[`CPU_OPCODE_WIDTH+`CPU_CODE_WIDTH-1:`CPU_CODE_WIDTH]);
	assign branchCode = branch_t'(OpcodeCondIn[`CPU_CODE_WIDTH-1:0]);
	assign intCode = intCode_t'(OpcodeCondIn[`CPU_CODE_WIDTH-1:0]);

	always_comb begin
		// Idle bus, nothing written
		ALE = 1'b0;
		AluEn = 1'b0;
		AluWe = 1'b0;
		AluOR = NoOr;
		ENB = 1'b0;
		ImmSel = ImmLong;
		IrWe = 1'b0;
		LrWe = 1'b0;
		MemEn = 1'b0;
		nME = 1'b1;
		nOE = 1'b1;
		nWE = 1'b1;
		Op1Sel = Op1Rd1;
		Op2Sel = Op2Imm;
		PcEn = 1'b0;
		PcSel = Pc1;
		PcWe = 1'b0;
		RegWe = 1'b0;
		Rs1Sel = Rs1Ra;
		RwSel = RwRd;
		WdSel = WdAlu;
		StatusRegWe = 1'b0;
		IntEnable = 1'b0;
		IntDisable = 1'b0;
		aluOp = 1'b0;
		case (State)
			fetch:
				case (Cycle)
					cycle0: begin
						ALE = 1'b1;
						PcEn = 1'b1;
					end
					cycle1: begin
						nME = 1'b0;
						PcEn = 1'b1;
					end
					// Instruction latched once the memory is ready
					cycle2: begin
						nME = 1'b0;
						nOE = 1'b0;
						MemEn = 1'b1;
						ENB = 1'b1;
						IrWe = nWait;
					end
					cycle3:
						PcEn = 1'b1;
					default: ;
				endcase
			execute:
				case (Cycle)
					cycle4:
						case (opcode)
							ADD, ADC, SUB, CMP, AND, OR, XOR, NAND, NOR: begin
								Op2Sel = Op2Rd2;
								aluOp = 1'b1;
							end
							ADDI, ADCI, SUBI, CMPI, LSL, LSR, ASR: begin
								ImmSel = ImmShort;
								aluOp = 1'b1;
							end
							// Byte immediates work on Rd in place
							ADDIB, SUBIB: begin
								Rs1Sel = Rs1Rd;
								aluOp = 1'b1;
							end
							SUC, SUCI, NOT, NEG:
								aluOp = 1'b1;
							LUI, LLI: begin
								Rs1Sel = Rs1Rd;
								AluEn = 1'b1;
								RegWe = 1'b1;
								PcWe = 1'b1;
							end
							// Address add before the bus cycle
							LDW, STW: begin
								ImmSel = ImmShort;
								AluEn = 1'b1;
								AluWe = 1'b1;
							end
							BRANCH:
								if (branchCode == JMP) begin
									ImmSel = ImmShort;
									AluEn = 1'b1;
									PcWe = 1'b1;
									PcSel = BranchTaken ? PcAluOut : Pc1;
								end else if (branchCode <= BWL) begin
									Op1Sel = Op1Pc;
									AluEn = 1'b1;
									PcWe = 1'b1;
									PcSel = BranchTaken ? PcAluOut : Pc1;
									LrWe = BranchTaken && (branchCode == BWL);
								end
							INTERRUPT:
								if (intCode == IntOn || intCode == IntOff) begin
									PcEn = 1'b1;
									PcWe = 1'b1;
									IntEnable = (intCode == IntOn);
									IntDisable = (intCode == IntOff);
								end
							default: ;
						endcase
					cycle0: begin
						ALE = 1'b1;
						ImmSel = ImmShort;
						AluEn = 1'b1;
					end
					// Pass Rd through the ALU for the data phase
					cycle1: begin
						nME = 1'b0;
						Op2Sel = Op2Zero;
						Rs1Sel = Rs1Rd;
						AluEn = 1'b1;
						AluWe = 1'b1;
					end
					cycle2: begin
						nME = 1'b0;
						PcWe = nWait;
						if (opcode == LDW) begin
							nOE = 1'b0;
							MemEn = 1'b1;
							ENB = 1'b1;
							WdSel = WdSys;
							RegWe = 1'b1;
						end else begin
							AluEn = 1'b1;
							Op2Sel = Op2Zero;
						end
					end
					cycle3:
						if (opcode == STW) begin
							nWE = 1'b0;
							AluEn = 1'b1;
							Op2Sel = Op2Zero;
						end else begin
							PcEn = 1'b1;
						end
					default: ;
				endcase
			interrupt:
				case (Cycle)
					// Drop the stack pointer by one word
					cycle4: begin
						IntDisable = 1'b1;
						Rs1Sel = Rs1Seven;
						AluOR = SubOr;
						Op2Sel = Op2Zero;
						AluEn = 1'b1;
						AluWe = 1'b1;
						RegWe = 1'b1;
						RwSel = RwSeven;
					end
					cycle0: begin
						ALE = 1'b1;
						Rs1Sel = Rs1Seven;
						AluOR = SubOr;
						Op2Sel = Op2Zero;
						AluEn = 1'b1;
					end
					cycle1: begin
						nME = 1'b0;
						Op2Sel = Op2Zero;
						AluEn = 1'b1;
					end
					// PC goes out on the bus for the push
					cycle2: begin
						nME = 1'b0;
						nWE = 1'b0;
						PcEn = 1'b1;
					end
					cycle3: begin
						PcEn = 1'b1;
						PcWe = 1'b1;
						PcSel = PcInt;
					end
					default: ;
				endcase
			default: ;
		endcase
		// Shared by every ALU opcode, compares keep the register file
		if (aluOp) begin
			PcEn = 1'b1;
			PcWe = 1'b1;
			StatusRegWe = 1'b1;
			RegWe = (opcode != CMP) && (opcode != CMPI);
		end
	end

endmodule

/* source/controlSequencer.sv */
// Major-state FSM choosing fetch, execute or interrupt entry
module controlSequencer (
	input  logic Clock,
	input  logic nReset,
	input  cpuControlPkg::busCycle_t Cycle,
	input  cpuControlPkg::opcode_t Opcode,
	input  logic IntReq,
	output cpuControlPkg::state_t State,
	output logic Load,
	output cpuControlPkg::busCycle_t LoadCycle
);

	import cpuControlPkg::*;

	state_t nextState;
	state_t endState;
	busCycle_t endCycle;

	// Where an instruction goes when it finishes
	assign endState = IntReq ? interrupt : fetch;
	assign endCycle = IntReq ? cycle4 : cycle0;

	always_comb begin
		Load = 1'b0;
		LoadCycle = cycle0;
		nextState = State;
		case (State)
			fetch:
				if (Cycle == cycle3) begin
					Load = 1'b1;
					LoadCycle = cycle4;
					nextState = execute;
				end
			execute:
				if (Cycle == cycle4) begin
					Load = 1'b1;
					// Memory ops continue with a bus cycle
					if (Opcode == LDW || Opcode == STW) begin
						LoadCycle = cycle0;
					end else begin
						LoadCycle = endCycle;
						nextState = endState;
					end
				end else if (Cycle == cycle3) begin
					Load = 1'b1;
					LoadCycle = endCycle;
					nextState = endState;
				end
			interrupt:
				case (Cycle)
					cycle4: begin
						Load = 1'b1;
						LoadCycle = cycle0;
					end
					// Push does not wait on nWait
					cycle2: begin
						Load = 1'b1;
						LoadCycle = cycle3;
					end
					cycle3: begin
						Load = 1'b1;
						LoadCycle = cycle0;
						nextState = fetch;
					end
					default: ;
				endcase
			default: begin
				Load = 1'b1;
				nextState = fetch;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			State <= fetch;
		else if (Load)
			State <= nextState;
	end

endmodule

/* source/cpuControl.sv */
// Control unit top level joining synchroniser, flags, counter, FSM and decoder
`include "cpuControl_params.svh"

module cpuControl (
	input  logic Clock,
	input  logic nReset,
	input  logic nIRQ,
	input  logic nWait,
	input  logic [`CPU_FLAG_WIDTH-1:0] Flags,
	input  logic [`CPU_OPCODE_WIDTH+`CPU_CODE_WIDTH-1:0] OpcodeCondIn,
	output logic ALE,
	output logic AluEn,
	output logic AluWe,
	output cpuControlPkg::aluOrSelect_t AluOR,
	output logic ENB,
	output cpuControlPkg::immSelect_t ImmSel,
	output logic IrWe,
	output logic LrWe,
	output logic MemEn,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output cpuControlPkg::op1Select_t Op1Sel,
	output cpuControlPkg::op2Select_t Op2Sel,
	output logic PcEn,
	output cpuControlPkg::pcSelect_t PcSel,
	output logic PcWe,
	output logic RegWe,
	output cpuControlPkg::rs1Select_t Rs1Sel,
	output cpuControlPkg::rwSelect_t RwSel,
	output cpuControlPkg::wdSelect_t WdSel,
	output logic StatusRegWe,
	output logic [`CPU_FLAG_WIDTH-1:0] StatusReg,
	output logic CFlag
);

	import cpuControlPkg::*;

	logic intReq;
	logic intEnable;
	logic intDisable;
	logic branchTaken;
	logic load;
	state_t state;
	busCycle_t cycle;
	busCycle_t loadCycle;
	opcode_t opcode;
	branch_t branchCode;

	// Instruction fields seen by the FSM and the flag logic
	assign opcode = opcode_t'(OpcodeCondIn[`CPU_OPCODE_WIDTH+`CPU_CODE_WIDTH-1:`CPU_CODE_WIDTH]);
	assign branchCode = branch_t'(OpcodeCondIn[`CPU_CODE_WIDTH-1:0]);

	irqSync u_irqSync (
		.Clock(Clock), .nReset(nReset), .nIRQ(nIRQ),
		.IntEnable(intEnable), .IntDisable(intDisable), .IntReq(intReq)
	);

	statusFlags u_statusFlags (
		.Clock(Clock), .nReset(nReset), .Flags(Flags), .StatusRegWe(StatusRegWe),
		.BranchCode(branchCode), .StatusReg(StatusReg), .CFlag(CFlag),
		.BranchTaken(branchTaken)
	);

	busCycleCounter u_busCycleCounter (
		.Clock(Clock), .nReset(nReset), .nWait(nWait),
		.Load(load), .LoadCycle(loadCycle), .Cycle(cycle)
	);

	controlSequencer u_controlSequencer (
		.Clock(Clock), .nReset(nReset), .Cycle(cycle), .Opcode(opcode),
		.IntReq(intReq), .State(state), .Load(load), .LoadCycle(loadCycle)
	);

	controlDecode u_controlDecode (
		.State(state), .Cycle(cycle), .OpcodeCondIn(OpcodeCondIn),
		.BranchTaken(branchTaken), .nWait(nWait),
		.ALE(ALE), .AluEn(AluEn), .AluWe(AluWe), .AluOR(AluOR), .ENB(ENB),
		.ImmSel(ImmSel), .IrWe(IrWe), .LrWe(LrWe), .MemEn(MemEn),
		.nME(nME), .nOE(nOE), .nWE(nWE), .Op1Sel(Op1Sel), .Op2Sel(Op2Sel),
		.PcEn(PcEn), .PcSel(PcSel), .PcWe(PcWe), .RegWe(RegWe),
		.Rs1Sel(Rs1Sel), .RwSel(RwSel), .WdSel(WdSel),
		.StatusRegWe(StatusRegWe), .IntEnable(intEnable), .IntDisable(intDisable)
	);

endmodule

/* source/cpuControlPkg.sv */
// State, sub-cycle, opcode, branch code and datapath select types
`include "cpuControl_params.svh"

package cpuControlPkg;

	// Major states of the sequencer
	typedef enum logic [1:0] {
		fetch,
		execute,
		interrupt
	} state_t;

	// Bus sub-cycles, cycle4 is the execute slot
	typedef enum logic [2:0] {
		cycle0,
		cycle1,
		cycle2,
		cycle3,
		cycle4
	} busCycle_t;

	typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
		ADD, ADDI, ADDIB, ADC, ADCI,
		SUB, SUBI, SUBIB, SUC, SUCI,
		CMP, CMPI, AND, OR, XOR,
		NOT, NAND, NOR, LSL, LSR,
		ASR, NEG, LUI, LLI, LDW,
		STW, BRANCH, INTERRUPT
	} opcode_t;

	// Low code field under BRANCH
	typedef enum logic [`CPU_CODE_WIDTH-1:0] {
		BR, BNE, BE, BLT, BGE, BWL, JMP
	} branch_t;

	// Low code field under INTERRUPT
	typedef enum logic [`CPU_CODE_WIDTH-1:0] {
		IntOn = 3'd1,
		IntOff = 3'd2
	} intCode_t;

	typedef enum logic [1:0] {Pc1, PcAluOut, PcInt} pcSelect_t;
	typedef enum logic {Op1Rd1, Op1Pc} op1Select_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2Select_t;
	typedef enum logic {ImmLong, ImmShort} immSelect_t;
	typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Seven} rs1Select_t;
	typedef enum logic {RwRd, RwSeven} rwSelect_t;
	typedef enum logic {WdAlu, WdSys} wdSelect_t;
	// Forces the ALU into subtract or add for stack pointer moves
	typedef enum logic [1:0] {NoOr, SubOr, AddOr} aluOrSelect_t;

endpackage

/* source/cpuControl_params.svh */
// Field widths, status flag positions and IRQ synchroniser depth
`ifndef CPU_CONTROL_PARAMS_SVH
`define CPU_CONTROL_PARAMS_SVH

// Instruction fields on OpcodeCondIn
`define CPU_OPCODE_WIDTH 5
`define CPU_CODE_WIDTH 3

// Status register layout
`define CPU_FLAG_WIDTH 4
`define CPU_FLAG_Z 0
`define CPU_FLAG_C 1
`define CPU_FLAG_V 2
`define CPU_FLAG_N 3

// Flip-flops between nIRQ and the request
`define CPU_IRQ_STAGES 2

`endif

/* source/irqSync.sv */
// nIRQ synchroniser and interrupt-enable flag
`include "cpuControl_params.svh"

module irqSync (
	input  logic Clock,
	input  logic nReset,
	input  logic nIRQ,
	input  logic IntEnable,
	input  logic IntDisable,
	output logic IntReq
);

	logic [`CPU_IRQ_STAGES-1:0] irqStages;
	logic intStatus;

	// Shift the inverted request towards the top stage
	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqStages <= '0;
			intStatus <= 1'b0;
		end else begin
			irqStages <= {irqStages[`CPU_IRQ_STAGES-2:0], ~nIRQ};
			// Disable has priority
			if (IntDisable)
				intStatus <= 1'b0;
			else if (IntEnable)
				intStatus <= 1'b1;
		end
	end

	assign IntReq = irqStages[`CPU_IRQ_STAGES-1] & intStatus;

endmodule

/* source/statusFlags.sv */
// Status register, carry output and branch condition check
`include "cpuControl_params.svh"

module statusFlags (
	input  logic Clock,
	input  logic nReset,
	input  logic [`CPU_FLAG_WIDTH-1:0] Flags,
	input  logic StatusRegWe,
	input  cpuControlPkg::branch_t BranchCode,
	output logic [`CPU_FLAG_WIDTH-1:0] StatusReg,
	output logic CFlag,
	output logic BranchTaken
);

	import cpuControlPkg::*;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			StatusReg <= '0;
		else if (StatusRegWe)
			StatusReg <= Flags;
	end

	assign CFlag = StatusReg[`CPU_FLAG_C];

	always_comb begin
		case (BranchCode)
			BNE:
				BranchTaken = ~StatusReg[`CPU_FLAG_Z];
			BE:
				BranchTaken = StatusReg[`CPU_FLAG_Z];
			// Signed compare from N and V
			BLT:
				BranchTaken = StatusReg[`CPU_FLAG_N] ^ StatusReg[`CPU_FLAG_V];
			BGE:
				BranchTaken = ~(StatusReg[`CPU_FLAG_N] ^ StatusReg[`CPU_FLAG_V]);
			BR, BWL, JMP:
				BranchTaken = 1'b1;
			default:
				BranchTaken = 1'b0;
		endcase
	end

endmodule
